/* hdl/ctrlPkg.sv */
package ctrlPkg;

	////////////////////////////////////////
	// Widths
	localparam int dataWidth = 16;  // Instruction word
	localparam int opWidth = 4;
	localparam int regWidth = 4;
	localparam int opExWidth = 4;
	localparam int immWidth = 8;
	localparam int psrWidth = 5;
	localparam int arbWidth = 3;    // Arbiter count

	localparam int linkReg = 15;       // Return address register for JAL
	localparam int cpuFirstSlot = 2;   // Slots 0 and 1 belong to video

	// Status register bit positions
	localparam int psrC = 0;
	localparam int psrL = 1;
	localparam int psrF = 2;
	localparam int psrZ = 3;
	localparam int psrN = 4;

	////////////////////////////////////////
	// Encodings
	typedef enum logic
	{
		FETCH = 1'b0,
		DECODE = 1'b1
	} ctrlState_t;

	typedef enum logic [opWidth-1:0]
	{
		RTYPE = 4'h0, ANDI = 4'h1, ORI = 4'h2, XORI = 4'h3,
		OTYPE = 4'h4, ADDI = 4'h5, ADDUI = 4'h6, STYPE = 4'h8,
		SUBI = 4'h9, CMPI = 4'hB, BCOND = 4'hC, MOVI = 4'hD,
		LUI = 4'hF
	} opcode_t;

	// Register ALU extensions, same codes as the immediate opcodes
	typedef enum logic [opExWidth-1:0]
	{
		AND = 4'h1, OR = 4'h2, XOR = 4'h3, ADD = 4'h5,
		ADDU = 4'h6, SUB = 4'h9, CMP = 4'hB, MOV = 4'hD
	} rExt_t;

	typedef enum logic [opExWidth-1:0]
	{
		JAL = 4'h8,
		JCOND = 4'hC,
		SCOND = 4'hD
	} oExt_t;

	typedef enum logic [opExWidth-1:0]
	{
		LLSHI = 4'h0, LRSHI = 4'h1, ALSHUI = 4'h2,
		ARSHUI = 4'h3, LSH = 4'h4, ASHU = 4'h6
	} sExt_t;

	typedef enum logic [regWidth-1:0]
	{
		EQ = 4'h0, NE = 4'h1, CS = 4'h2, CC = 4'h3, HI = 4'h4,
		LS = 4'h5, GT = 4'h6, LE = 4'h7, FS = 4'h8, FC = 4'h9,
		LO = 4'hA, HS = 4'hB, LT = 4'hC, GE = 4'hD, UC = 4'hE
	} cond_t;

	typedef enum logic [3:0]
	{
		ALU_NOP, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_MOV, ALU_LUI, ALU_SLL, ALU_SRL, ALU_SLA, ALU_SRA
	} aluOp_t;

	// Register file write-back source
	typedef enum logic [1:0]
	{
		WB_LINK = 2'd0,
		WB_COND = 2'd1,
		WB_ALU = 2'd2
	} wbSel_t;

endpackage

/* hdl/fetchSequencer.sv */
`timescale 1ns/1ps

module fetchSequencer import ctrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic [arbWidth-1:0] acnt,
	input logic [dataWidth-1:0] instruction,
	output ctrlState_t state,
	output logic [dataWidth-1:0] inst
);

	logic cpuSlot;
	ctrlState_t nextState;

	// Processor owns every slot from cpuFirstSlot up
	assign cpuSlot = (acnt >= arbWidth'(cpuFirstSlot));

	// Two states only, so the next one is always the other
	assign nextState = (state == FETCH) ? DECODE : FETCH;

	////////////////////////////////////////
	// State register

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= FETCH;
		else if (cpuSlot)
			state <= nextState;  // Video slots hold the state
	end

	////////////////////////////////////////
	// Instruction latch

	// Follows the ROM while fetching, so the word at the edge
	// leaving FETCH is the one held through decode
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			inst <= '0;
		else if (state == FETCH)
			inst <= instruction;
	end

endmodule

/* hdl/conditionUnit.sv */
`timescale 1ns/1ps

module conditionUnit import ctrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic psrEn,
	input logic [psrWidth-1:0] psrIn,
	input cond_t condCode,
	output logic condTrue
);

	logic [psrWidth-1:0] psr;
	logic flagC;
	logic flagL;
	logic flagF;
	logic flagZ;
	logic flagN;

	////////////////////////////////////////
	// Status register

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			psr <= '0;
		else if (psrEn)
			psr <= psrIn;  // Flags from the ALU
	end

	assign flagC = psr[psrC];
	assign flagL = psr[psrL];
	assign flagF = psr[psrF];
	assign flagZ = psr[psrZ];
	assign flagN = psr[psrN];

	////////////////////////////////////////
	// Condition evaluation

	always_comb
	begin
		case (condCode)
			EQ: condTrue = flagZ;
			NE: condTrue = ~flagZ;
			CS: condTrue = flagC;
			CC: condTrue = ~flagC;
			HI: condTrue = flagL;
			LS: condTrue = ~flagL;
			GT: condTrue = flagN;
			LE: condTrue = ~flagN;
			FS: condTrue = flagF;
			FC: condTrue = ~flagF;
			HS: condTrue = flagZ | flagL;        // Higher or same
			GE: condTrue = flagZ | flagN;
			LO: condTrue = ~(flagZ | flagL);
			LT: condTrue = ~(flagZ | flagN);
			UC: condTrue = 1'b1;                 // Unconditional
			default: condTrue = 1'b0;
		endcase
	end

endmodule

/* hdl/instructionDecoder.sv */
`timescale 1ns/1ps

module instructionDecoder import ctrlPkg::*;
(
	input ctrlState_t state,
	input logic [dataWidth-1:0] inst,
	input logic condTrue,
	output cond_t condCode,
	output logic psrEn,
	output logic romCe,
	output logic romOe,
	output logic branch,
	output logic jump,
	output logic immMux,
	output logic pcEn,
	output logic regWrite,
	output logic condResult,
	output wbSel_t wbSel,
	output logic [regWidth-1:0] rDst,
	output logic [regWidth-1:0] rSrc,
	output logic [immWidth-1:0] immVal,
	output aluOp_t aluOp
);

	opcode_t opcode;
	logic [regWidth-1:0] dstField;
	logic [opExWidth-1:0] extField;
	logic [regWidth-1:0] srcField;
	logic [immWidth-1:0] immField;
	logic [immWidth-1:0] shiftImm;

	// Shared mapping for register and immediate ALU forms
	function automatic aluOp_t aluMap(input logic [opExWidth-1:0] code);
		case (rExt_t'(code))
			AND: aluMap = ALU_AND;
			OR: aluMap = ALU_OR;
			XOR: aluMap = ALU_XOR;
			ADD: aluMap = ALU_ADD;
			ADDU: aluMap = ALU_ADDU;
			SUB, CMP: aluMap = ALU_SUB;  // Compare is a subtract
			MOV: aluMap = ALU_MOV;
			default: aluMap = ALU_NOP;
		endcase
	endfunction

	////////////////////////////////////////
	// Field split

	assign opcode = opcode_t'(inst[dataWidth-1 -: opWidth]);
	assign dstField = inst[dataWidth-opWidth-1 -: regWidth];
	assign extField = inst[dataWidth-opWidth-regWidth-1 -: opExWidth];
	assign srcField = inst[regWidth-1:0];
	assign immField = inst[immWidth-1:0];
	assign shiftImm = {{(immWidth-regWidth){1'b0}}, srcField};  // Zero extended

	// Jump carries its condition in the destination field
	assign condCode = (opcode == OTYPE && oExt_t'(extField) == JCOND) ?
		cond_t'(dstField) : cond_t'(srcField);

	////////////////////////////////////////
	// Control levels

	always_comb
	begin
		psrEn = 1'b0;
		romCe = 1'b1;  // Active low
		romOe = 1'b1;  // Active low
		branch = 1'b0;
		jump = 1'b0;
		immMux = 1'b0;
		pcEn = 1'b0;
		regWrite = 1'b0;
		condResult = 1'b0;
		wbSel = WB_ALU;
		rDst = '0;
		rSrc = '0;
		immVal = '0;
		aluOp = ALU_NOP;
		if (state == FETCH)
		begin
			romCe = 1'b0;
			romOe = 1'b0;
		end
		else
		begin
			case (opcode)
				ANDI, ORI, XORI, ADDI, ADDUI, SUBI, CMPI, MOVI, LUI:
				begin
					rDst = dstField;
					immVal = immField;
					aluOp = (opcode == LUI) ? ALU_LUI : aluMap(opcode);
					immMux = 1'b1;
					pcEn = 1'b1;
					psrEn = 1'b1;
					regWrite = (opcode != CMPI);
				end
				RTYPE:
				begin
					aluOp = aluMap(extField);
					if (aluOp != ALU_NOP)  // Unknown extension keeps defaults
					begin
						rDst = dstField;
						rSrc = srcField;
						pcEn = 1'b1;
						psrEn = 1'b1;
						regWrite = (rExt_t'(extField) != CMP);
					end
				end
				STYPE:
				begin
					case (sExt_t'(extField))
						LSH: aluOp = ALU_SLL;
						ASHU: aluOp = ALU_SLA;
						LLSHI: aluOp = ALU_SLL;
						LRSHI: aluOp = ALU_SRL;
						ALSHUI: aluOp = ALU_SLA;
						ARSHUI: aluOp = ALU_SRA;
						default: aluOp = ALU_NOP;
					endcase
					// Shifts write but leave the flags alone
					if (aluOp != ALU_NOP)
					begin
						rDst = dstField;
						regWrite = 1'b1;
						pcEn = 1'b1;
						if (sExt_t'(extField) == LSH || sExt_t'(extField) == ASHU)
							rSrc = srcField;
						else
							immVal = shiftImm;
					end
				end
				BCOND:
				begin
					immVal = immField;  // Branch displacement
					immMux = 1'b1;
					pcEn = 1'b1;
					branch = condTrue && condCode != UC;
				end
				OTYPE:
				begin
					case (oExt_t'(extField))
						JAL:
						begin
							jump = 1'b1;
							rDst = regWidth'(linkReg);
							rSrc = srcField;
							regWrite = 1'b1;
							wbSel = WB_LINK;
							pcEn = 1'b1;
						end
						JCOND:
						begin
							rSrc = srcField;  // Target address register
							jump = condTrue;
							pcEn = 1'b1;
						end
						SCOND:
						begin
							rDst = dstField;
							regWrite = 1'b1;
							wbSel = WB_COND;
							condResult = condTrue && condCode != UC;
							pcEn = 1'b1;
						end
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

/* hdl/controller.sv */
`timescale 1ns/1ps

module controller import ctrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic [arbWidth-1:0] acnt,           // Memory arbiter count
	input logic [dataWidth-1:0] instruction,   // From ROM
	input logic [psrWidth-1:0] psrIn,          // ALU flags
	output ctrlState_t ps,
	output logic branch,
	output logic jump,
	output logic immMux,
	output logic pcEn,
	output logic regWrite,
	output logic romCe,
	output logic romOe,
	output logic condResult,
	output wbSel_t wbSel,
	output logic [regWidth-1:0] rDst,
	output logic [regWidth-1:0] rSrc,
	output logic [immWidth-1:0] immVal,
	output aluOp_t aluOp
);

	logic [dataWidth-1:0] inst;
	logic psrEn;
	logic condTrue;
	cond_t condCode;

	fetchSequencer fetchSequencer_i
	(
		.clk(clk),
		.rst(rst),
		.acnt(acnt),
		.instruction(instruction),
		.state(ps),
		.inst(inst)
	);

	conditionUnit conditionUnit_i
	(
		.clk(clk),
		.rst(rst),
		.psrEn(psrEn),
		.psrIn(psrIn),
		.condCode(condCode),
		.condTrue(condTrue)
	);

	instructionDecoder instructionDecoder_i
	(
		.state(ps),
		.inst(inst),
		.condTrue(condTrue),
		.condCode(condCode),
		.psrEn(psrEn),
		.romCe(romCe),
		.romOe(romOe),
		.branch(branch),
		.jump(jump),
		.immMux(immMux),
		.pcEn(pcEn),
		.regWrite(regWrite),
		.condResult(condResult),
		.wbSel(wbSel),
		.rDst(rDst),
		.rSrc(rSrc),
		.immVal(immVal),
		.aluOp(aluOp)
	);

endmodule

/* verification/controller_properties.sv */
`timescale 1ns/1ps

module controller_properties import ctrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic [arbWidth-1:0] acnt,
	input ctrlState_t ps,
	input logic romCe,
	input logic pcEn,
	input logic regWrite,
	input logic branch,
	input logic jump
);

	// Video slots never move the state
	stateHold: assert property (@(posedge clk) disable iff (!rst)
		(acnt < arbWidth'(cpuFirstSlot)) |=> $stable(ps))
		else $error("ps changed on a video slot");

	romEnable: assert property (@(posedge clk) disable iff (!rst)
		((romCe == 1'b0) == (ps == FETCH)))
		else $error("romCe does not follow the fetch state");

	fetchQuiet: assert property (@(posedge clk) disable iff (!rst)
		(ps == FETCH) |-> (!pcEn && !regWrite))
		else $error("pcEn or regWrite high in fetch");

	oneTransfer: assert property (@(posedge clk) disable iff (!rst)
		!(branch && jump))
		else $error("branch and jump high together");

endmodule

bind controller controller_properties props_i
(
	.clk(clk),
	.rst(rst),
	.acnt(acnt),
	.ps(ps),
	.romCe(romCe),
	.pcEn(pcEn),
	.regWrite(regWrite),
	.branch(branch),
	.jump(jump)
);

/* verification/controllerTb.sv */
`timescale 1ns/1ps

module controllerTb import ctrlPkg::*;
();

	typedef struct
	{
		string name;
		logic [dataWidth-1:0] instr;
		logic [psrWidth-1:0] psr;
		aluOp_t aluOp;
		logic [regWidth-1:0] rDst;
		logic [regWidth-1:0] rSrc;
		logic [immWidth-1:0] imm;
		logic rw;
		logic immMux;
		wbSel_t wb;
		logic br;
		logic jp;
		logic cr;
	} row_t;

	logic clk;
	logic rst;
	logic [arbWidth-1:0] acnt;
	logic [dataWidth-1:0] instruction;
	logic [psrWidth-1:0] psrIn;
	ctrlState_t ps;
	logic branch, jump, immMux, pcEn, regWrite, romCe, romOe, condResult;
	wbSel_t wbSel;
	logic [regWidth-1:0] rDst, rSrc;
	logic [immWidth-1:0] immVal;
	aluOp_t aluOp;

	row_t rows[$];
	logic [psrWidth-1:0] flagModel;  // Flags as the DUT should hold them
	int condNext;
	int cycleCount;
	int cycleLimit;
	int errorCount;

	controller dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Arbiter slot counter, wraps 7 to 0
	always @(posedge clk)
		acnt <= #1 acnt + 1'b1;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("Run stalled: no progress after %0d cycles", cycleCount);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	////////////////////////////////////////
	// Expected values

	// Condition rule on a flag word
	function automatic logic condHolds(input cond_t c, input logic [psrWidth-1:0] f);
		case (c)
			EQ: return f[psrZ];
			NE: return !f[psrZ];
			CS: return f[psrC];
			CC: return !f[psrC];
			HI: return f[psrL];
			LS: return !f[psrL];
			GT: return f[psrN];
			LE: return !f[psrN];
			FS: return f[psrF];
			FC: return !f[psrF];
			HS: return f[psrZ] || f[psrL];
			GE: return f[psrZ] || f[psrN];
			LO: return !(f[psrZ] || f[psrL]);
			LT: return !(f[psrZ] || f[psrN]);
			UC: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic row_t blankRow(input string name, input logic [dataWidth-1:0] instr);
		row_t r;
		r.name = name;
		r.instr = instr;
		r.psr = psrWidth'($urandom);
		r.aluOp = ALU_NOP;
		r.rDst = '0;
		r.rSrc = '0;
		r.imm = '0;
		r.rw = 1'b0;
		r.immMux = 1'b0;
		r.wb = WB_ALU;
		r.br = 1'b0;
		r.jp = 1'b0;
		r.cr = 1'b0;
		return r;
	endfunction

	// One conditional row, kind 0 branch, 1 jump, 2 set
	task automatic addCond(input cond_t c, input int kind);
		row_t r;
		logic [3:0] a;
		logic [3:0] b;
		a = 4'($urandom);
		b = 4'($urandom);
		if (kind == 0)
		begin
			r = blankRow($sformatf("bcond_%0h", c), {4'hC, a, b, 4'(c)});
			r.imm = {b, 4'(c)};
			r.immMux = 1'b1;
			r.br = condHolds(c, flagModel) && c != UC;
		end
		else if (kind == 1)
		begin
			r = blankRow($sformatf("jcond_%0h", c), {4'h4, 4'(c), 4'hC, a});
			r.rSrc = a;
			r.jp = condHolds(c, flagModel);
		end
		else
		begin
			r = blankRow($sformatf("scond_%0h", c), {4'h4, a, 4'hD, 4'(c)});
			r.rDst = a;
			r.rw = 1'b1;
			r.wb = WB_COND;
			r.cr = condHolds(c, flagModel) && c != UC;
		end
		rows.push_back(r);
	endtask

	task automatic addNextCond();
		if (condNext < 15)
		begin
			addCond(cond_t'(condNext), condNext % 3);
			condNext++;
		end
	endtask

	task automatic addImm(input string name, input opcode_t op, input logic [3:0] d,
		input logic [7:0] imm, input aluOp_t op2);
		row_t r;
		r = blankRow(name, {4'(op), d, imm});
		r.aluOp = op2;
		r.rDst = d;
		r.imm = imm;
		r.rw = (op != CMPI);
		r.immMux = 1'b1;
		flagModel = r.psr;
		rows.push_back(r);
		addNextCond();
	endtask

	task automatic addReg(input string name, input rExt_t ext, input logic [3:0] d,
		input logic [3:0] s, input aluOp_t op2);
		row_t r;
		r = blankRow(name, {4'h0, d, 4'(ext), s});
		r.aluOp = op2;
		r.rDst = d;
		r.rSrc = s;
		r.rw = (ext != CMP);
		flagModel = r.psr;
		rows.push_back(r);
		addNextCond();
	endtask

	// Shifts leave the flag model untouched
	task automatic addShift(input string name, input sExt_t ext, input logic [3:0] d,
		input logic [3:0] s, input aluOp_t op2, input logic isImm);
		row_t r;
		r = blankRow(name, {4'h8, d, 4'(ext), s});
		r.psr = ~flagModel;  // Every flag differs if a shift loaded them
		r.aluOp = op2;
		r.rDst = d;
		r.rw = 1'b1;
		if (isImm)
			r.imm = {4'h0, s};
		else
			r.rSrc = s;
		rows.push_back(r);
	endtask

	task automatic buildTable();
		row_t r;
		addImm("addi", ADDI, 4'h3, 8'h5A, ALU_ADD);
		addImm("andi", ANDI, 4'h7, 8'hF0, ALU_AND);
		addImm("ori", ORI, 4'hA, 8'h0C, ALU_OR);
		addImm("xori", XORI, 4'h1, 8'hFF, ALU_XOR);
		addImm("addui", ADDUI, 4'h4, 8'h80, ALU_ADDU);
		addImm("subi", SUBI, 4'hC, 8'h01, ALU_SUB);
		addImm("cmpi", CMPI, 4'h2, 8'h11, ALU_SUB);
		addImm("movi", MOVI, 4'h5, 8'hAA, ALU_MOV);
		addImm("lui", LUI, 4'h6, 8'h12, ALU_LUI);
		addReg("and", AND, 4'h3, 4'h4, ALU_AND);
		addReg("or", OR, 4'h5, 4'h8, ALU_OR);
		addReg("xor", XOR, 4'hA, 4'hB, ALU_XOR);
		addReg("add", ADD, 4'h1, 4'h6, ALU_ADD);
		addReg("addu", ADDU, 4'hE, 4'hF, ALU_ADDU);
		addReg("sub", SUB, 4'h2, 4'h1, ALU_SUB);
		addReg("cmp", CMP, 4'h4, 4'h7, ALU_SUB);
		addReg("mov", MOV, 4'h9, 4'hC, ALU_MOV);
		addShift("llshi", LLSHI, 4'h3, 4'h5, ALU_SLL, 1'b1);
		addShift("lrshi", LRSHI, 4'h4, 4'hF, ALU_SRL, 1'b1);
		addShift("alshui", ALSHUI, 4'h5, 4'h3, ALU_SLA, 1'b1);
		addShift("arshui", ARSHUI, 4'h6, 4'hA, ALU_SRA, 1'b1);
		addShift("lsh", LSH, 4'h7, 4'h2, ALU_SLL, 1'b0);
		addShift("ashu", ASHU, 4'h8, 4'h9, ALU_SLA, 1'b0);
		addCond(EQ, 2);  // Flags must have survived the shifts
		addCond(UC, 0);  // Unconditional branch stays low
		addCond(UC, 1);
		r = blankRow("jal", {4'h4, 4'($urandom), 4'h8, 4'hB});
		r.jp = 1'b1;
		r.rDst = 4'(linkReg);
		r.rSrc = 4'hB;
		r.rw = 1'b1;
		r.wb = WB_LINK;
		rows.push_back(r);
	endtask

	////////////////////////////////////////
	// Checking

	task automatic checkValue(input string test, input string field, input int expected,
		input int actual);
		assert (actual == expected)
		else
		begin
			errorCount++;
			$display("** Error %s %s: expected %0h, actual %0h", test, field, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic applyRow(input row_t r);
		int decodeCycles;
		instruction = r.instr;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (ps != DECODE);
		psrIn = r.psr;
		checkValue(r.name, "aluOp", r.aluOp, aluOp);
		checkValue(r.name, "rDst", r.rDst, rDst);
		checkValue(r.name, "rSrc", r.rSrc, rSrc);
		checkValue(r.name, "immVal", r.imm, immVal);
		checkValue(r.name, "regWrite", r.rw, regWrite);
		checkValue(r.name, "immMux", r.immMux, immMux);
		checkValue(r.name, "wbSel", r.wb, wbSel);
		checkValue(r.name, "branch", r.br, branch);
		checkValue(r.name, "jump", r.jp, jump);
		checkValue(r.name, "condResult", r.cr, condResult);
		checkValue(r.name, "pcEn", 1, pcEn);
		checkValue(r.name, "romCe", 1, romCe);
		checkValue(r.name, "romOe", 1, romOe);
		decodeCycles = 0;
		do
		begin
			@(posedge clk);
			#1;
			decodeCycles++;
		end
		while (ps != FETCH);
		assert (decodeCycles <= 3)
		else
		begin
			errorCount++;
			$display("Decode of %s lasted %0d cycles, more than three", r.name, decodeCycles);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	initial
	begin
		void'($urandom(32'h73ad));
		rst = 1'b0;
		acnt = 3'd3;  // Odd start so some decodes wait out the video slots
		instruction = '0;
		psrIn = '0;
		flagModel = '0;
		condNext = 0;
		cycleCount = 0;
		errorCount = 0;
		buildTable();
		cycleLimit = rows.size() * 16 + 200;
		repeat (16) @(posedge clk);
		#1;
		checkValue("reset", "ps", FETCH, ps);
		checkValue("reset", "romCe", 0, romCe);
		checkValue("reset", "romOe", 0, romOe);
		checkValue("reset", "pcEn", 0, pcEn);
		checkValue("reset", "regWrite", 0, regWrite);
		checkValue("reset", "branch", 0, branch);
		checkValue("reset", "jump", 0, jump);
		rst = 1'b1;
		foreach (rows[i])
			applyRow(rows[i]);
		if (errorCount == 0)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
		begin
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

endmodule

/* src.f */
hdl/ctrlPkg.sv
hdl/fetchSequencer.sv
hdl/conditionUnit.sv
hdl/instructionDecoder.sv
hdl/controller.sv
verification/controller_properties.sv
verification/controllerTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= controllerTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

PASS_TEXT := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
